//--- common/rv_exec_pkg.sv
package rv_exec_pkg;

    localparam int DATA_WIDTH  = 32;
    localparam int SHAMT_WIDTH = 5;
    localparam int QUEUE_DEPTH = 4;
    localparam int TAG_WIDTH   = 4;

    // RV32I major opcodes handled by the execute path.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_NONE,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLT,
        ALU_SLTU,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_JALR
    } alu_type_e;

    // Decoded operation, one queue entry.
    typedef struct packed {
        alu_type_e               alu_type;
        logic [DATA_WIDTH-1:0]   opa;      // rs1 value.
        logic [DATA_WIDTH-1:0]   opb;      // rs2 or immediate.
        logic [TAG_WIDTH-1:0]    tag;
    } alu_op_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]   res;
        logic                    zero;
        logic                    over;
        logic                    neg;
        logic [TAG_WIDTH-1:0]    tag;
    } alu_res_t;

endpackage

//--- alu/alu.sv
module alu (
    input  rv_exec_pkg::alu_type_e                i_alu_type,
    input  logic [rv_exec_pkg::DATA_WIDTH-1:0]    i_alu_rs1_data,
    input  logic [rv_exec_pkg::DATA_WIDTH-1:0]    i_alu_rs2_data,
    output logic [rv_exec_pkg::DATA_WIDTH-1:0]    o_alu_res,
    output logic                                  o_alu_zero,
    output logic                                  o_alu_over,
    output logic                                  o_alu_neg
);

    logic signed [rv_exec_pkg::DATA_WIDTH-1:0]    w_s_rs1_data;
    logic signed [rv_exec_pkg::DATA_WIDTH-1:0]    w_s_rs2_data;
    logic [rv_exec_pkg::SHAMT_WIDTH-1:0]          w_shamt;
    logic [rv_exec_pkg::DATA_WIDTH-1:0]           w_sum;
    logic                                         w_flag;
    logic                                         w_rs1_sign;
    logic                                         w_rs2_sign;
    logic                                         w_res_sign;

    assign w_s_rs1_data = i_alu_rs1_data;
    assign w_s_rs2_data = i_alu_rs2_data;
    assign w_shamt      = i_alu_rs2_data[rv_exec_pkg::SHAMT_WIDTH-1:0];
    assign w_sum        = i_alu_rs1_data + i_alu_rs2_data;

    // Compare outcome, lands in bit 0.
    always_comb begin
        case (i_alu_type)
            rv_exec_pkg::ALU_SLT,
            rv_exec_pkg::ALU_BLT:  w_flag = (w_s_rs1_data < w_s_rs2_data);
            rv_exec_pkg::ALU_BGE:  w_flag = (w_s_rs1_data >= w_s_rs2_data);
            rv_exec_pkg::ALU_SLTU,
            rv_exec_pkg::ALU_BLTU: w_flag = (i_alu_rs1_data < i_alu_rs2_data);
            rv_exec_pkg::ALU_BGEU: w_flag = (i_alu_rs1_data >= i_alu_rs2_data);
            rv_exec_pkg::ALU_BEQ:  w_flag = (i_alu_rs1_data == i_alu_rs2_data);
            rv_exec_pkg::ALU_BNE:  w_flag = (i_alu_rs1_data != i_alu_rs2_data);
            default:               w_flag = 1'b0;
        endcase
    end

    always_comb begin
        case (i_alu_type)
            rv_exec_pkg::ALU_SLL:  o_alu_res = i_alu_rs1_data << w_shamt;
            rv_exec_pkg::ALU_SRL:  o_alu_res = i_alu_rs1_data >> w_shamt;
            rv_exec_pkg::ALU_SRA:  o_alu_res = w_s_rs1_data >>> w_shamt; // Sign fill.
            rv_exec_pkg::ALU_ADD:  o_alu_res = w_sum;
            rv_exec_pkg::ALU_SUB:  o_alu_res = i_alu_rs1_data - i_alu_rs2_data;
            rv_exec_pkg::ALU_XOR:  o_alu_res = i_alu_rs1_data ^ i_alu_rs2_data;
            rv_exec_pkg::ALU_OR:   o_alu_res = i_alu_rs1_data | i_alu_rs2_data;
            rv_exec_pkg::ALU_AND:  o_alu_res = i_alu_rs1_data & i_alu_rs2_data;
            rv_exec_pkg::ALU_JALR: o_alu_res = {w_sum[rv_exec_pkg::DATA_WIDTH-1:1], 1'b0};
            rv_exec_pkg::ALU_SLT,
            rv_exec_pkg::ALU_SLTU,
            rv_exec_pkg::ALU_BEQ,
            rv_exec_pkg::ALU_BNE,
            rv_exec_pkg::ALU_BLT,
            rv_exec_pkg::ALU_BGE,
            rv_exec_pkg::ALU_BLTU,
            rv_exec_pkg::ALU_BGEU: o_alu_res = {{(rv_exec_pkg::DATA_WIDTH - 1){1'b0}}, w_flag};
            default:               o_alu_res = '0;
        endcase
    end

    assign w_rs1_sign = i_alu_rs1_data[rv_exec_pkg::DATA_WIDTH-1];
    assign w_rs2_sign = i_alu_rs2_data[rv_exec_pkg::DATA_WIDTH-1];
    assign w_res_sign = o_alu_res[rv_exec_pkg::DATA_WIDTH-1];

    assign o_alu_zero = (o_alu_res == '0);
    assign o_alu_neg  = w_res_sign;

    // Two's-complement overflow, both directions.
    assign o_alu_over =
        ((i_alu_type == rv_exec_pkg::ALU_ADD) &&
         (w_rs1_sign == w_rs2_sign) && (w_res_sign != w_rs1_sign)) ||
        ((i_alu_type == rv_exec_pkg::ALU_SUB) &&
         (w_rs1_sign != w_rs2_sign) && (w_res_sign != w_rs1_sign));

endmodule

//--- alu/alu_exec.sv
module alu_exec (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_empty,
    input  logic                    i_hold,
    input  rv_exec_pkg::alu_op_t    i_op,
    output logic                    o_pop,
    output logic                    o_res_valid,
    output rv_exec_pkg::alu_res_t   o_res
);

    logic [rv_exec_pkg::DATA_WIDTH-1:0] w_res;
    logic                               w_zero;
    logic                               w_over;
    logic                               w_neg;

    assign o_pop = !i_empty && !i_hold;

    alu u_alu (
        .i_alu_type     (i_op.alu_type),
        .i_alu_rs1_data (i_op.opa),
        .i_alu_rs2_data (i_op.opb),
        .o_alu_res      (w_res),
        .o_alu_zero     (w_zero),
        .o_alu_over     (w_over),
        .o_alu_neg      (w_neg)
    );

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_res_valid <= 1'b0;
        end else begin
            o_res_valid <= o_pop;
        end
    end

    // Result holds its value until the next pop.
    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            o_res.res  <= w_res;
            o_res.zero <= w_zero;
            o_res.over <= w_over;
            o_res.neg  <= w_neg;
            o_res.tag  <= i_op.tag;
        end
    end

    // A waiting operation keeps its value until it is popped.
    a_head_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (!i_empty && i_hold) |=> $stable(i_op))
        else $error("alu_exec: waiting operation changed before its pop");

    // Decoder never queues an empty operation.
    a_pop_not_none: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_pop |-> (i_op.alu_type != rv_exec_pkg::ALU_NONE))
        else $error("alu_exec: popped ALU_NONE");

endmodule

//--- design/inst_decoder.sv
module inst_decoder (
    input  logic                                 i_clk,
    input  logic                                 i_arst_n,
    input  logic                                 i_inst_valid,
    input  logic [31:0]                          i_inst,
    input  logic [rv_exec_pkg::DATA_WIDTH-1:0]   i_rs1_data,
    input  logic [rv_exec_pkg::DATA_WIDTH-1:0]   i_rs2_data,
    input  logic [rv_exec_pkg::TAG_WIDTH-1:0]    i_tag,
    output logic                                 o_op_valid,
    output rv_exec_pkg::alu_op_t                 o_op,
    output logic                                 o_illegal
);

    rv_exec_pkg::opcode_e                 w_opcode;
    logic [2:0]                           w_funct3;
    logic [6:0]                           w_funct7;
    logic                                 w_f7_zero;
    logic                                 w_f7_alt;
    logic [rv_exec_pkg::DATA_WIDTH-1:0]   w_imm_i;
    rv_exec_pkg::alu_type_e               w_arith_type;
    rv_exec_pkg::alu_op_t                 w_op;
    logic                                 w_legal;

    assign w_opcode  = rv_exec_pkg::opcode_e'(i_inst[6:0]);
    assign w_funct3  = i_inst[14:12];
    assign w_funct7  = i_inst[31:25];
    assign w_f7_zero = (w_funct7 == 7'b0000000);
    assign w_f7_alt  = (w_funct7 == 7'b0100000);
    assign w_imm_i   = {{(rv_exec_pkg::DATA_WIDTH - 12){i_inst[31]}}, i_inst[31:20]};

    // Shared by OP and OP-IMM; funct7 bit 5 picks SUB and SRA.
    always_comb begin
        case (w_funct3)
            3'b000:  w_arith_type = w_funct7[5] ? rv_exec_pkg::ALU_SUB : rv_exec_pkg::ALU_ADD;
            3'b001:  w_arith_type = rv_exec_pkg::ALU_SLL;
            3'b010:  w_arith_type = rv_exec_pkg::ALU_SLT;
            3'b011:  w_arith_type = rv_exec_pkg::ALU_SLTU;
            3'b100:  w_arith_type = rv_exec_pkg::ALU_XOR;
            3'b101:  w_arith_type = w_funct7[5] ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
            3'b110:  w_arith_type = rv_exec_pkg::ALU_OR;
            default: w_arith_type = rv_exec_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        w_op.alu_type = rv_exec_pkg::ALU_NONE;
        w_op.opa      = i_rs1_data;
        w_op.opb      = w_imm_i;
        w_op.tag      = i_tag;
        w_legal       = 1'b0;
        case (w_opcode)
            rv_exec_pkg::OPC_OP: begin
                w_op.alu_type = w_arith_type;
                w_op.opb      = i_rs2_data;
                if (w_funct3 == 3'b000 || w_funct3 == 3'b101) begin
                    w_legal = w_f7_zero || w_f7_alt;
                end else begin
                    w_legal = w_f7_zero;
                end
            end
            rv_exec_pkg::OPC_OP_IMM: begin
                w_op.alu_type = w_arith_type;
                w_legal       = 1'b1;
                if (w_funct3 == 3'b000) begin
                    w_op.alu_type = rv_exec_pkg::ALU_ADD; // No SUBI.
                end else if (w_funct3 == 3'b001 || w_funct3 == 3'b101) begin
                    w_op.opb = {{(rv_exec_pkg::DATA_WIDTH - rv_exec_pkg::SHAMT_WIDTH){1'b0}},
                                i_inst[20 +: rv_exec_pkg::SHAMT_WIDTH]};
                    w_legal  = (w_funct3 == 3'b001) ? w_f7_zero : (w_f7_zero || w_f7_alt);
                end
            end
            rv_exec_pkg::OPC_BRANCH: begin
                w_op.opb = i_rs2_data;
                w_legal  = 1'b1;
                case (w_funct3)
                    3'b000:  w_op.alu_type = rv_exec_pkg::ALU_BEQ;
                    3'b001:  w_op.alu_type = rv_exec_pkg::ALU_BNE;
                    3'b100:  w_op.alu_type = rv_exec_pkg::ALU_BLT;
                    3'b101:  w_op.alu_type = rv_exec_pkg::ALU_BGE;
                    3'b110:  w_op.alu_type = rv_exec_pkg::ALU_BLTU;
                    3'b111:  w_op.alu_type = rv_exec_pkg::ALU_BGEU;
                    default: w_legal       = 1'b0;
                endcase
            end
            rv_exec_pkg::OPC_JALR: begin
                w_op.alu_type = rv_exec_pkg::ALU_JALR;
                w_legal       = (w_funct3 == 3'b000);
            end
            default: w_legal = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_op_valid <= 1'b0;
            o_illegal  <= 1'b0;
        end else begin
            o_op_valid <= i_inst_valid && w_legal;
            o_illegal  <= i_inst_valid && !w_legal;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_inst_valid) begin
            o_op <= w_op;
        end
    end

endmodule

//--- design/op_queue.sv
module op_queue (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  logic                   i_push,
    input  rv_exec_pkg::alu_op_t   i_op,
    input  logic                   i_pop,
    output rv_exec_pkg::alu_op_t   o_head,
    output logic                   o_full,
    output logic                   o_empty
);

    rv_exec_pkg::alu_op_t                            r_mem [rv_exec_pkg::QUEUE_DEPTH];
    logic [$clog2(rv_exec_pkg::QUEUE_DEPTH)-1:0]     r_wr_ptr;
    logic [$clog2(rv_exec_pkg::QUEUE_DEPTH)-1:0]     r_rd_ptr;
    logic [$clog2(rv_exec_pkg::QUEUE_DEPTH + 1)-1:0] r_count;
    logic                                            w_push;
    logic                                            w_pop;

    assign o_full  = (r_count == rv_exec_pkg::QUEUE_DEPTH);
    assign o_empty = (r_count == '0);
    assign o_head  = r_mem[r_rd_ptr];

    assign w_pop  = i_pop && !o_empty;
    assign w_push = i_push && (!o_full || w_pop); // Full queue still takes a push on pop.

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (w_push) begin
                r_wr_ptr <= r_wr_ptr + 1'b1; // Depth is a power of two.
            end
            if (w_pop) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
            if (w_push && !w_pop) begin
                r_count <= r_count + 1'b1;
            end else if (w_pop && !w_push) begin
                r_count <= r_count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_push) begin
            r_mem[r_wr_ptr] <= i_op;
        end
    end

    // Decoder strobe arriving at a full queue would lose an operation.
    a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_push && o_full) |-> i_pop)
        else $error("op_queue: push while full");

    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_pop |-> !o_empty)
        else $error("op_queue: pop while empty");

endmodule

//--- design/exec_unit_top.sv
module exec_unit_top (
    input  logic                                 i_clk,
    input  logic                                 i_arst_n,
    input  logic                                 i_inst_valid,
    input  logic [31:0]                          i_inst,
    input  logic [rv_exec_pkg::DATA_WIDTH-1:0]   i_rs1_data,
    input  logic [rv_exec_pkg::DATA_WIDTH-1:0]   i_rs2_data,
    input  logic [rv_exec_pkg::TAG_WIDTH-1:0]    i_tag,
    input  logic                                 i_hold,
    output logic                                 o_full,
    output logic                                 o_illegal,
    output logic                                 o_res_valid,
    output rv_exec_pkg::alu_res_t                o_res
);

    logic                   w_op_valid;
    rv_exec_pkg::alu_op_t   w_op;
    rv_exec_pkg::alu_op_t   w_head;
    logic                   w_empty;
    logic                   w_pop;

    inst_decoder u_inst_decoder (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .i_rs1_data   (i_rs1_data),
        .i_rs2_data   (i_rs2_data),
        .i_tag        (i_tag),
        .o_op_valid   (w_op_valid),
        .o_op         (w_op),
        .o_illegal    (o_illegal)
    );

    op_queue u_op_queue (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_push   (w_op_valid),
        .i_op     (w_op),
        .i_pop    (w_pop),
        .o_head   (w_head),
        .o_full   (o_full),
        .o_empty  (w_empty)
    );

    alu_exec u_alu_exec (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_empty     (w_empty),
        .i_hold      (i_hold),
        .i_op        (w_head),
        .o_pop       (w_pop),
        .o_res_valid (o_res_valid),
        .o_res       (o_res)
    );

endmodule

//--- sim/tb_exec_unit.sv
module tb_exec_unit;
    timeunit 1ns;
    timeprecision 1ps;

    logic                  i_clk = 1'b0;
    logic                  i_arst_n;
    logic                  i_inst_valid;
    logic [31:0]           i_inst;
    logic [31:0]           i_rs1_data;
    logic [31:0]           i_rs2_data;
    logic [3:0]            i_tag;
    logic                  i_hold;
    logic                  o_full;
    logic                  o_illegal;
    logic                  o_res_valid;
    rv_exec_pkg::alu_res_t o_res;

    rv_exec_pkg::alu_res_t exp_q [$];  // Expected results in issue order.
    logic [15:0]           lfsr = 16'd13657;
    logic [3:0]            next_tag = '0;
    logic                  held = 1'b0;
    logic                  full_seen = 1'b0;
    logic [31:0]           limits [4] = '{32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h1};
    int                    exp_illegal = 0;
    int                    illegal_seen = 0;
    int                    passes = 0;
    int                    fails = 0;
    int                    test_fails = 0;
    int                    tests_ok = 0;
    int                    tests_bad = 0;

    exec_unit_top uut (.*);

    always #10 i_clk = ~i_clk;

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {imm, 5'd1, f3, 5'd3, opc};
    endfunction

    // Expected result from the RV32I field rules; returns 0 for an illegal word.
    function automatic logic ref_model(input logic [31:0] inst, input logic [31:0] a,
                                       input logic [31:0] rs2, input logic [3:0] tag,
                                       output rv_exec_pkg::alu_res_t r);
        logic [6:0]         opc;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic [31:0]        b;
        logic [31:0]        y;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               legal;
        logic               add;
        logic               sub;
        opc = inst[6:0];
        f3  = inst[14:12];
        f7  = inst[31:25];
        b   = (opc == 7'h33 || opc == 7'h63) ? rs2 : {{20{inst[31]}}, inst[31:20]};
        if (opc == 7'h13 && f3[1:0] == 2'b01) begin
            b = {27'd0, inst[24:20]};  // Shift immediates carry shamt only.
        end
        sa    = a;
        sb    = b;
        y     = '0;
        legal = 1'b0;
        add   = 1'b0;
        sub   = 1'b0;
        if (opc == 7'h33 || opc == 7'h13) begin
            sub   = (opc == 7'h33) && (f3 == 3'd0) && f7[5];
            add   = (f3 == 3'd0) && !sub;
            legal = (f7 == 7'h00) || (opc == 7'h13 && f3[1:0] != 2'b01) ||
                    (f7 == 7'h20 && (f3 == 3'd5 || (f3 == 3'd0 && opc == 7'h33)));
            case (f3)
                3'd0: y = sub ? a - b : a + b;
                3'd1: y = a << b[4:0];
                3'd2: y = {31'd0, sa < sb};
                3'd3: y = {31'd0, a < b};
                3'd4: y = a ^ b;
                3'd5: begin
                    if (f7[5]) begin
                        y = sa >>> b[4:0];
                    end else begin
                        y = a >> b[4:0];
                    end
                end
                3'd6: y = a | b;
                default: y = a & b;
            endcase
        end else if (opc == 7'h63) begin
            legal = (f3 != 3'd2) && (f3 != 3'd3);
            case (f3)
                3'd0: y = {31'd0, a == b};
                3'd1: y = {31'd0, a != b};
                3'd4: y = {31'd0, sa < sb};
                3'd5: y = {31'd0, sa >= sb};
                3'd6: y = {31'd0, a < b};
                default: y = {31'd0, a >= b};
            endcase
        end else if (opc == 7'h67) begin
            legal = (f3 == 3'd0);
            y     = (a + b) & ~32'd1;
        end
        r.res  = y;
        r.zero = (y == '0);
        r.neg  = y[31];
        r.over = (add && a[31] == b[31] && y[31] != a[31]) ||
                 (sub && a[31] != b[31] && y[31] != a[31]);
        r.tag  = tag;
        return legal;
    endfunction

    task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
            fails++;
        end else begin
            passes++;
        end
    endtask

    // One instruction every third cycle keeps at most one push in flight.
    task automatic issue(input logic [31:0] inst, input logic [31:0] a, input logic [31:0] b);
        rv_exec_pkg::alu_res_t exp;
        @(posedge i_clk);
        while (o_full) begin
            @(posedge i_clk);
        end
        i_inst_valid <= 1'b1;
        i_inst       <= inst;
        i_rs1_data   <= a;
        i_rs2_data   <= b;
        i_tag        <= next_tag;
        if (ref_model(inst, a, b, next_tag, exp)) begin
            exp_q.push_back(exp);
        end else begin
            exp_illegal++;
        end
        next_tag++;
        @(posedge i_clk);
        i_inst_valid <= 1'b0;
        @(posedge i_clk);
    endtask

    task automatic issue_arith();
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        f3 = 3'(rand_bits(3));
        if (f3[1:0] == 2'b01) begin
            f3 = 3'd0;
        end
        a = rand_bits(32);
        b = (rand_bits(2) == 0) ? a : rand_bits(32);  // Equal operands exercise zero.
        if (rand_bits(1) != 0) begin
            issue(enc_r((f3 == 3'd0 && rand_bits(1) != 0) ? 7'h20 : 7'h00, f3, 7'h33), a, b);
        end else begin
            issue(enc_i(12'(rand_bits(12)), f3, 7'h13), a, b);
        end
    endtask

    task automatic end_test(input string name);
        while (exp_q.size() != 0) begin
            @(posedge i_clk);
        end
        repeat (4) @(posedge i_clk);
        compare(64'(illegal_seen), 64'(exp_illegal), "illegal pulse count");
        $display("test %s finished with %0d errors", name, fails - test_fails);
        if (fails == test_fails) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        test_fails   = fails;
        exp_illegal  = 0;
        illegal_seen = 0;
    endtask

    task automatic arith_ops();
        repeat (40) issue_arith();
        end_test("arith");
    endtask

    task automatic shift_ops();
        logic [2:0] f3;
        logic [6:0] f7;
        repeat (30) begin
            f3 = (rand_bits(1) != 0) ? 3'd5 : 3'd1;
            f7 = (f3 == 3'd5 && rand_bits(1) != 0) ? 7'h20 : 7'h00;
            if (rand_bits(1) != 0) begin
                issue(enc_r(f7, f3, 7'h33), rand_bits(32), rand_bits(32));
            end else begin
                issue(enc_i({f7, 5'(rand_bits(5))}, f3, 7'h13), rand_bits(32), 32'd0);
            end
        end
        end_test("shift");
    endtask

    task automatic branch_compares();
        logic [2:0]  f3;
        logic [31:0] a;
        logic [1:0]  mode;
        repeat (30) begin
            f3 = 3'(rand_bits(3));
            if (f3 == 3'd2 || f3 == 3'd3) begin
                f3 = f3 + 3'd4;
            end
            a    = rand_bits(32);
            mode = 2'(rand_bits(2));
            case (mode)
                2'd0: issue(enc_r(7'h00, f3, 7'h63), a, a);
                2'd1: issue(enc_r(7'h00, f3, 7'h63), a, a ^ 32'h8000_0000);
                default: issue(enc_r(7'h00, f3, 7'h63), a, rand_bits(32));
            endcase
        end
        end_test("branch");
    endtask

    task automatic limit_cases();
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                issue(enc_r(7'h00, 3'd0, 7'h33), limits[i], limits[j]);
                issue(enc_r(7'h20, 3'd0, 7'h33), limits[i], limits[j]);
            end
        end
        repeat (10) issue(enc_i(12'(rand_bits(12)), 3'd0, 7'h67), rand_bits(32), 32'd0);
        end_test("limits and jalr");
    endtask

    task automatic hold_stretch();
        int len;
        len       = 20 + int'(rand_bits(4));
        full_seen = 1'b0;
        @(posedge i_clk);
        i_hold <= 1'b1;
        fork
            begin
                repeat (len) @(posedge i_clk);
                i_hold <= 1'b0;
            end
            repeat (16) issue_arith();
        join
        compare(64'(full_seen), 64'd1, "o_full raised during hold");
        end_test("hold");
    endtask

    task automatic illegal_words();
        logic [31:0] word;
        for (int i = 0; i < 8; i++) begin
            case (i)
                0: word = enc_r(7'h01, 3'd0, 7'h33);
                1: word = enc_r(7'h20, 3'd2, 7'h33);
                2: word = enc_i(12'h405, 3'd1, 7'h13);
                3: word = enc_i(12'h203, 3'd5, 7'h13);
                4: word = enc_r(7'h00, 3'd2, 7'h63);
                5: word = enc_i(12'h010, 3'd1, 7'h67);
                6: word = enc_i(12'h000, 3'd2, 7'h03);  // Load, outside this path.
                default: word = enc_i(12'h123, 3'd0, 7'h37);
            endcase
            issue(word, rand_bits(32), rand_bits(32));
            issue_arith();
        end
        end_test("illegal");
    endtask

    always @(posedge i_clk) begin
        rv_exec_pkg::alu_res_t exp;
        if (i_arst_n) begin
            if (o_full) begin
                full_seen = 1'b1;
            end
            if (o_illegal) begin
                illegal_seen++;
            end
            if (o_res_valid && held) begin
                $display("result with tag %0d came out while hold was high", o_res.tag);
                fails++;
            end
            if (o_res_valid && exp_q.size() == 0) begin
                $display("result with tag %0d arrived but none was expected", o_res.tag);
                fails++;
            end else if (o_res_valid) begin
                exp = exp_q.pop_front();
                compare(64'(o_res), 64'(exp), $sformatf("result tag %0d", exp.tag));
            end
            held = i_hold;
        end
    end

    // 174 instructions, 20 cycles of 20 ns each.
    initial begin
        #(174 * 20 * 20);
        $display("timeout: %0d results still pending at %0t", exp_q.size(), $time);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        i_arst_n     = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        i_rs1_data   = '0;
        i_rs2_data   = '0;
        i_tag        = '0;
        i_hold       = 1'b0;
        repeat (16) @(posedge i_clk);
        i_arst_n <= 1'b1;
        arith_ops();
        shift_ops();
        branch_compares();
        limit_cases();
        hold_stretch();
        illegal_words();
        $display("tests ok %0d bad %0d, checks ok %0d bad %0d", tests_ok, tests_bad, passes, fails);
        if (fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- list.f
common/rv_exec_pkg.sv
alu/alu.sv
alu/alu_exec.sv
design/inst_decoder.sv
design/op_queue.sv
design/exec_unit_top.sv
sim/tb_exec_unit.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_exec_unit \
    -f list.f -o tb_exec_unit
./obj_dir/tb_exec_unit | tee sim.log
if grep -qx "Simulation passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
